/* verilog/sgemm_pkg.sv */
package sgemm_pkg;

	// ------------------------------------------------------------
	// Line and array geometry
	// ------------------------------------------------------------
	localparam int CL_WIDTH = 512;
	localparam int DATA_W   = 32;
	localparam int LANES    = CL_WIDTH / DATA_W;
	localparam int NUM_ROWS = 2;
	// Must not exceed LANES
	localparam int NUM_COL  = 3;

	// Lines per row or column per block
	localparam int BLOCK_LINES   = 4;
	localparam int A_BLOCK_LINES = NUM_ROWS * BLOCK_LINES;
	localparam int B_BLOCK_LINES = NUM_COL * BLOCK_LINES;

	// ------------------------------------------------------------
	// Host bus fields
	// ------------------------------------------------------------
	localparam int ADDR_W  = 20;
	localparam int TID_W   = 16;
	localparam int MDATA_W = 14;
	localparam int CNT_W   = 16;

	// Region bases, in cache lines
	localparam logic [ADDR_W-1:0] A_BASE = 20'h00000;
	localparam logic [ADDR_W-1:0] B_BASE = 20'h40000;
	localparam logic [ADDR_W-1:0] C_BASE = 20'h80000;
	// Gap between C bursts
	localparam int C_BURST_STRIDE = 64;

	// Output FIFO, depth a power of two
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_AFULL = 12;

	// ------------------------------------------------------------
	// FSM encodings
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		RD_IDLE,
		RD_CALC1,
		RD_CALC2,
		RD_DONE,
		RD_SEND,
		RD_NEXT,
		RD_FIN
	} rd_state_e;

	typedef enum logic [1:0] {
		WB_IDLE,
		WB_SEND,
		WB_WAIT,
		WB_END
	} wb_state_e;

	// One cache line, packed per lane or read as one word
	typedef union packed {
		logic [LANES-1:0][DATA_W-1:0] lanes;
		logic [CL_WIDTH-1:0]          flat;
	} cl_line_u;

endpackage

/* verilog/pe_line_if.sv */
`timescale 1ns/100ps

interface pe_line_if
	import sgemm_pkg::*;
	();

	// Pop strobe from the write-back side
	logic     rd_req;
	// Registered FIFO head, valid one cycle after a pop
	cl_line_u line;
	logic     empty;
	logic     almost_full;
	// PE valid, one cycle late
	logic     filling;

	modport buffer_side (
		input  rd_req,
		output line,
		output empty,
		output almost_full,
		output filling
	);

	modport drain_side (
		output rd_req,
		input  line,
		input  empty,
		input  filling
	);

endinterface

/* verilog/rd_req_seq.sv */
`timescale 1ns/100ps

module rd_req_seq
	import sgemm_pkg::*;
(
	input  logic              Clk_16UI,
	input  logic              rst,
	input  logic              go,
	input  logic [CNT_W-1:0]  num_blocks,
	input  logic [CNT_W-1:0]  num_parts_a,
	input  logic [CNT_W-1:0]  num_parts_b,
	input  logic              rd_sent,
	input  logic              stall_rd,
	input  logic              a_mem_full,
	input  logic              b_mem_full,
	output logic              rd_en,
	output logic [ADDR_W-1:0] rd_addr,
	output logic [TID_W-1:0]  rd_tid,
	output logic              a_b_workspace_sel
);

	rd_state_e          state;
	// Block position: B part outermost, then A part, then block
	logic [CNT_W-1:0]   part_a;
	logic [CNT_W-1:0]   part_b;
	logic [CNT_W-1:0]   blk_idx;
	// Lines accepted in the current block
	logic [CNT_W-1:0]   line_cnt;
	logic [MDATA_W-1:0] rd_mdata;
	// Offset pipeline, block number then line offset
	logic [ADDR_W-1:0]  blk_lin;
	logic [ADDR_W-1:0]  blk_ofs;
	logic               accept;
	logic               last_line;
	logic               last_blk;
	logic               last_pa;
	logic               last_pb;

	// Request only into a channel that has room
	assign rd_en = (state == RD_SEND) && !stall_rd &&
		!(a_b_workspace_sel ? b_mem_full : a_mem_full);
	assign accept = rd_en && rd_sent;
	assign rd_tid = TID_W'(rd_mdata);

	assign last_line = a_b_workspace_sel ? (line_cnt == CNT_W'(B_BLOCK_LINES - 1)) :
		(line_cnt == CNT_W'(A_BLOCK_LINES - 1));
	assign last_blk = (blk_idx == num_blocks - 1'b1);
	assign last_pa  = (part_a == num_parts_a - 1'b1);
	assign last_pb  = (part_b == num_parts_b - 1'b1);

	// ------------------------------------------------------------
	// Read FSM and block counters
	// ------------------------------------------------------------
	always_ff @(posedge Clk_16UI)
	begin
		if (rst)
		begin
			state             <= RD_IDLE;
			part_a            <= '0;
			part_b            <= '0;
			blk_idx           <= '0;
			line_cnt          <= '0;
			a_b_workspace_sel <= 1'b0;
		end
		else
		begin
			case (state)
				RD_IDLE:
				begin
					if (go)
						state <= RD_CALC1;
				end
				RD_CALC1:
					state <= RD_CALC2;
				RD_CALC2:
					state <= RD_DONE;
				RD_DONE:
				begin
					line_cnt <= '0;
					state    <= RD_SEND;
				end
				RD_SEND:
				begin
					if (accept)
					begin
						line_cnt <= line_cnt + 1'b1;
						if (last_line)
						begin
							// A done goes to B, B done closes the block
							a_b_workspace_sel <= !a_b_workspace_sel;
							state             <= a_b_workspace_sel ? RD_NEXT : RD_CALC1;
						end
					end
				end
				RD_NEXT:
				begin
					state <= RD_CALC1;
					if (!last_blk)
						blk_idx <= blk_idx + 1'b1;
					else
					begin
						blk_idx <= '0;
						if (!last_pa)
							part_a <= part_a + 1'b1;
						else
						begin
							part_a <= '0;
							if (!last_pb)
								part_b <= part_b + 1'b1;
							else
								state <= RD_FIN;
						end
					end
				end
				// Whole workload issued
				default:
					state <= state;
			endcase
		end
	end

	// Two stage offset, multiplier kept off the add
	always_ff @(posedge Clk_16UI)
	begin
		if (state == RD_CALC1)
			blk_lin <= (a_b_workspace_sel ? part_b : part_a) * num_blocks + blk_idx;
		if (state == RD_CALC2)
			blk_ofs <= a_b_workspace_sel ? blk_lin * ADDR_W'(B_BLOCK_LINES) :
				blk_lin * ADDR_W'(A_BLOCK_LINES);
		if (state == RD_DONE)
			rd_addr <= (a_b_workspace_sel ? B_BASE : A_BASE) + blk_ofs;
		else if (accept)
			rd_addr <= rd_addr + 1'b1;
	end

	// Read TID wraps every A block
	always_ff @(posedge Clk_16UI)
	begin
		if (rst)
			rd_mdata <= '0;
		else if (accept)
			rd_mdata <= (rd_mdata == MDATA_W'(A_BLOCK_LINES - 1)) ? '0 : rd_mdata + 1'b1;
	end

endmodule

/* verilog/rd_rsp_router.sv */
`timescale 1ns/100ps

module rd_rsp_router
	import sgemm_pkg::*;
(
	input  logic                Clk_16UI,
	input  logic                rst,
	input  logic                go,
	input  logic                rd_rsp_valid,
	input  logic [ADDR_W-1:0]   rd_rsp_addr,
	input  logic [CL_WIDTH-1:0] rd_data,
	output logic                a_mem_wr_req,
	output logic [CL_WIDTH-1:0] a_mem_data,
	output logic [ADDR_W-1:0]   a_mem_addr,
	output logic                b_mem_wr_req,
	output logic [CL_WIDTH-1:0] b_mem_data,
	output logic [ADDR_W-1:0]   b_mem_addr
);

	// Set by the first go
	logic             active;
	// High while the B block is being filled
	logic             fill_b;
	logic [CNT_W-1:0] rsp_cnt;
	logic             to_a;
	logic             to_b;
	logic             grp_end;

	assign to_a = active && rd_rsp_valid && !fill_b;
	assign to_b = active && rd_rsp_valid && fill_b;
	assign grp_end = fill_b ? (rsp_cnt == CNT_W'(B_BLOCK_LINES - 1)) :
		(rsp_cnt == CNT_W'(A_BLOCK_LINES - 1));

	// ------------------------------------------------------------
	// Response count per block group
	// ------------------------------------------------------------
	always_ff @(posedge Clk_16UI)
	begin
		if (rst)
		begin
			active  <= 1'b0;
			fill_b  <= 1'b0;
			rsp_cnt <= '0;
		end
		else if (!active)
		begin
			// Start with an A group
			active  <= go;
			fill_b  <= 1'b0;
			rsp_cnt <= '0;
		end
		else if (rd_rsp_valid)
		begin
			if (grp_end)
			begin
				rsp_cnt <= '0;
				fill_b  <= !fill_b;
			end
			else
				rsp_cnt <= rsp_cnt + 1'b1;
		end
	end

	// Channel outputs, zero unless writing
	always_ff @(posedge Clk_16UI)
	begin
		if (rst)
		begin
			a_mem_wr_req <= 1'b0;
			b_mem_wr_req <= 1'b0;
		end
		else
		begin
			a_mem_wr_req <= to_a;
			b_mem_wr_req <= to_b;
		end
		a_mem_data <= to_a ? rd_data : '0;
		a_mem_addr <= to_a ? rd_rsp_addr : '0;
		b_mem_data <= to_b ? rd_data : '0;
		b_mem_addr <= to_b ? rd_rsp_addr : '0;
	end

endmodule

/* verilog/pe_out_buffer.sv */
`timescale 1ns/100ps

module pe_out_buffer
	import sgemm_pkg::*;
(
	input  logic                            Clk_16UI,
	input  logic                            rst,
	input  logic                            pe_out_valid,
	input  logic [NUM_COL-1:0][DATA_W-1:0]  pe_out_block,
	pe_line_if.buffer_side                  bus,
	output logic                            writes_fifo_full
);

	cl_line_u              mem [FIFO_DEPTH];
	cl_line_u              packed_line;
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	// One extra bit so a full FIFO is countable
	logic [FIFO_PTR_W:0]   count;
	logic                  push;
	logic                  pop;

	// Column words into the low lanes, rest zero
	always_comb
	begin
		packed_line.flat = '0;
		for (int c = 0; c < NUM_COL; c++)
			packed_line.lanes[c] = pe_out_block[c];
	end

	assign push = pe_out_valid && (count != (FIFO_PTR_W + 1)'(FIFO_DEPTH));
	assign pop  = bus.rd_req && !bus.empty;

	assign bus.empty       = (count == '0);
	assign bus.almost_full = (count >= (FIFO_PTR_W + 1)'(FIFO_AFULL));

	// ------------------------------------------------------------
	// FIFO pointers and flags
	// ------------------------------------------------------------
	always_ff @(posedge Clk_16UI)
	begin
		if (rst)
		begin
			wr_ptr           <= '0;
			rd_ptr           <= '0;
			count            <= '0;
			bus.filling      <= 1'b0;
			writes_fifo_full <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			bus.filling      <= pe_out_valid;
			writes_fifo_full <= bus.almost_full;
		end
	end

	// Line storage and registered head
	always_ff @(posedge Clk_16UI)
	begin
		if (push)
			mem[wr_ptr] <= packed_line;
		if (pop)
			bus.line <= mem[rd_ptr];
	end

endmodule

/* verilog/c_writeback.sv */
`timescale 1ns/100ps

module c_writeback
	import sgemm_pkg::*;
(
	input  logic                Clk_16UI,
	input  logic                rst,
	input  logic                wr_sent,
	input  logic                wr_rsp_valid,
	input  logic                wr_alm_full,
	input  logic [CNT_W-1:0]    expected_wr_rsp,
	pe_line_if.drain_side       bus,
	output logic                wr_en,
	output logic [ADDR_W-1:0]   wr_addr,
	output logic [TID_W-1:0]    wr_tid,
	output logic [CL_WIDTH-1:0] wr_din,
	output logic                test_cmp
);

	wb_state_e          state;
	logic [CNT_W-1:0]   burst_idx;
	// Next line address inside the burst
	logic [ADDR_W-1:0]  line_addr;
	logic               pop;
	logic               pop_q;
	logic [MDATA_W-1:0] wr_mdata;
	logic [CNT_W-1:0]   rsp_cnt;

	assign pop    = bus.rd_req && !bus.empty;
	assign wr_tid = TID_W'(wr_mdata);

	// ------------------------------------------------------------
	// Burst FSM
	// ------------------------------------------------------------
	always_ff @(posedge Clk_16UI)
	begin
		if (rst)
		begin
			state      <= WB_IDLE;
			bus.rd_req <= 1'b0;
			burst_idx  <= '0;
		end
		else
		begin
			case (state)
				WB_IDLE:
				begin
					if (!bus.empty)
					begin
						bus.rd_req <= !wr_alm_full;
						state      <= wr_alm_full ? WB_WAIT : WB_SEND;
					end
				end
				WB_SEND:
				begin
					// Drained and no PE line on the way
					if (bus.empty && !bus.filling)
					begin
						bus.rd_req <= 1'b0;
						state      <= WB_END;
					end
					else if (wr_alm_full)
					begin
						bus.rd_req <= 1'b0;
						state      <= WB_WAIT;
					end
				end
				WB_WAIT:
				begin
					// Drained while paused
					if (bus.empty && !bus.filling)
						state <= WB_END;
					else if (!wr_alm_full)
					begin
						bus.rd_req <= 1'b1;
						state      <= WB_SEND;
					end
				end
				default:
				begin
					burst_idx <= burst_idx + 1'b1;
					state     <= WB_IDLE;
				end
			endcase
		end
	end

	// Burst base set while idle, then one step per line
	always_ff @(posedge Clk_16UI)
	begin
		if (state == WB_IDLE)
			line_addr <= C_BASE + ADDR_W'(burst_idx * C_BURST_STRIDE);
		else if (pop_q)
			line_addr <= line_addr + 1'b1;
		if (pop_q)
		begin
			wr_addr <= line_addr;
			wr_din  <= bus.line.flat;
		end
	end

	// Write strobe two cycles after the pop, TIDs and responses
	always_ff @(posedge Clk_16UI)
	begin
		if (rst)
		begin
			pop_q    <= 1'b0;
			wr_en    <= 1'b0;
			wr_mdata <= '0;
			rsp_cnt  <= '0;
			test_cmp <= 1'b0;
		end
		else
		begin
			pop_q <= pop;
			wr_en <= pop_q;
			if (wr_en && wr_sent)
				wr_mdata <= wr_mdata + 1'b1;
			if (wr_rsp_valid)
				rsp_cnt <= rsp_cnt + 1'b1;
			// Sticky once every expected response is back
			if (expected_wr_rsp != '0 && rsp_cnt == expected_wr_rsp)
				test_cmp <= 1'b1;
		end
	end

endmodule

/* verilog/sgemm_ctrl_top.sv */
`timescale 1ns/100ps

module sgemm_ctrl_top
	import sgemm_pkg::*;
(
	input  logic                           Clk_16UI,
	input  logic                           rst,
	// Workload setup
	input  logic                           go,
	input  logic [CNT_W-1:0]               num_blocks,
	input  logic [CNT_W-1:0]               num_parts_a,
	input  logic [CNT_W-1:0]               num_parts_b,
	input  logic [CNT_W-1:0]               expected_wr_rsp,
	// Arbiter read side
	input  logic                           rd_sent,
	input  logic                           stall_rd,
	input  logic                           rd_rsp_valid,
	input  logic [ADDR_W-1:0]              rd_rsp_addr,
	input  logic [CL_WIDTH-1:0]            rd_data,
	output logic                           rd_en,
	output logic [ADDR_W-1:0]              rd_addr,
	output logic [TID_W-1:0]               rd_tid,
	// Arbiter write side
	input  logic                           wr_sent,
	input  logic                           wr_rsp_valid,
	input  logic                           wr_alm_full,
	output logic                           wr_en,
	output logic [ADDR_W-1:0]              wr_addr,
	output logic [TID_W-1:0]               wr_tid,
	output logic [CL_WIDTH-1:0]            wr_din,
	output logic                           test_cmp,
	// Systolic array feed
	input  logic                           a_mem_full,
	input  logic                           b_mem_full,
	output logic                           a_mem_wr_req,
	output logic [CL_WIDTH-1:0]            a_mem_data,
	output logic [ADDR_W-1:0]              a_mem_addr,
	output logic                           b_mem_wr_req,
	output logic [CL_WIDTH-1:0]            b_mem_data,
	output logic [ADDR_W-1:0]              b_mem_addr,
	output logic                           a_b_workspace_sel,
	// PE results
	input  logic                           pe_out_valid,
	input  logic [NUM_COL-1:0][DATA_W-1:0] pe_out_block,
	output logic                           writes_fifo_full
);

	// Output FIFO to write-back link
	pe_line_if line_if ();

	rd_req_seq u_rd_seq (.*);

	rd_rsp_router u_rsp_router (.*);

	pe_out_buffer u_out_buf (
		.bus (line_if.buffer_side),
		.*
	);

	c_writeback u_wb (
		.bus (line_if.drain_side),
		.*
	);

endmodule

/* bench/tb_sgemm_ctrl.sv */
`timescale 1ns/100ps

module tb_sgemm_ctrl
	import sgemm_pkg::*;
	();

	localparam int HDR     = 5;
	localparam int GROUP   = A_BLOCK_LINES + B_BLOCK_LINES;
	localparam int TIMEOUT = 4000;
	localparam int T_RST   = 0;
	localparam int T_RD    = 1;
	localparam int T_RT    = 2;
	localparam int T_WD    = 3;
	localparam int T_TID   = 4;
	localparam int T_CMP   = 5;
	localparam int N_TESTS = 6;

	logic                           Clk_16UI;
	logic                           rst;
	logic                           go;
	logic [CNT_W-1:0]               num_blocks;
	logic [CNT_W-1:0]               num_parts_a;
	logic [CNT_W-1:0]               num_parts_b;
	logic [CNT_W-1:0]               expected_wr_rsp;
	logic                           rd_sent;
	logic                           stall_rd;
	logic                           rd_rsp_valid;
	logic [ADDR_W-1:0]              rd_rsp_addr;
	logic [CL_WIDTH-1:0]            rd_data;
	logic                           rd_en;
	logic [ADDR_W-1:0]              rd_addr;
	logic [TID_W-1:0]               rd_tid;
	logic                           wr_sent;
	logic                           wr_rsp_valid;
	logic                           wr_alm_full;
	logic                           wr_en;
	logic [ADDR_W-1:0]              wr_addr;
	logic [TID_W-1:0]               wr_tid;
	logic [CL_WIDTH-1:0]            wr_din;
	logic                           test_cmp;
	logic                           a_mem_full;
	logic                           b_mem_full;
	logic                           a_mem_wr_req;
	logic [CL_WIDTH-1:0]            a_mem_data;
	logic [ADDR_W-1:0]              a_mem_addr;
	logic                           b_mem_wr_req;
	logic [CL_WIDTH-1:0]            b_mem_data;
	logic [ADDR_W-1:0]              b_mem_addr;
	logic                           a_b_workspace_sel;
	logic                           pe_out_valid;
	logic [NUM_COL-1:0][DATA_W-1:0] pe_out_block;
	logic                           writes_fifo_full;

	// Header words then PE vectors
	logic [31:0] pat [0:255];
	string       test_name [N_TESTS] = '{"reset", "read_seq", "rsp_route",
		"write_data", "write_tid", "completion"};
	int          errs [N_TESTS];
	integer      seed;
	int          nblk, npa, npb, vec_cnt, grp1, exp_rsp, total_rd;
	int          rd_acc, routed, rsp_idx, wr_seen, wr_pending, wr_rsp_sent;
	int          blocked, full_hold, t, total_err, n_fail, rsp_dut;
	bit          full_done, cmp_seen, cmp_exp;
	// Expected read order, reads awaiting a response, responses awaiting routing
	logic [ADDR_W-1:0] exp_rd [$];
	logic [ADDR_W-1:0] rsp_q [$];
	logic [ADDR_W:0]   route_q [$];
	logic [ADDR_W-1:0] exp_addr;
	logic [ADDR_W-1:0] rsp_addr;
	logic [ADDR_W-1:0] exp_waddr;
	logic [ADDR_W:0]   exp_rt;
	logic [CL_WIDTH-1:0] exp_line;

	sgemm_ctrl_top dut0 (.*);

	always #10 Clk_16UI = ~Clk_16UI;

	// ------------------------------------------------------------
	// Reporting and reference models
	// ------------------------------------------------------------
	task automatic mismatch(input int tst, input logic [CL_WIDTH-1:0] expected,
		input logic [CL_WIDTH-1:0] actual);
		$display("[ERROR] %s: expected %0h, actual %0h", test_name[tst], expected, actual);
		errs[tst]++;
	endtask

	task automatic problem(input int tst, input string what);
		$display("%s: %s", test_name[tst], what);
		errs[tst]++;
	endtask

	task automatic finish_test(input int tst);
		$display("Test %s: %s, %0d errors", test_name[tst],
			errs[tst] == 0 ? "ok" : "failed", errs[tst]);
	endtask

	// Arbiter read data, line address copied into every lane
	function automatic logic [CL_WIDTH-1:0] rsp_line(input logic [ADDR_W-1:0] addr);
		logic [CL_WIDTH-1:0] l;
		for (int i = 0; i < LANES; i++)
			l[i*DATA_W +: DATA_W] = DATA_W'(addr);
		return l;
	endfunction

	// Vector k in the low lanes, upper lanes zero
	function automatic logic [CL_WIDTH-1:0] pe_line(input int k);
		logic [CL_WIDTH-1:0] l;
		l = '0;
		for (int c = 0; c < NUM_COL; c++)
			l[c*DATA_W +: DATA_W] = pat[HDR + k * NUM_COL + c];
		return l;
	endfunction

	task automatic check_reset_outputs();
		assert ({rd_en, wr_en, a_mem_wr_req, b_mem_wr_req, test_cmp, writes_fifo_full,
			a_b_workspace_sel} == 7'b0)
		else
			mismatch(T_RST, 7'b0, {rd_en, wr_en, a_mem_wr_req, b_mem_wr_req, test_cmp,
				writes_fifo_full, a_b_workspace_sel});
	endtask

	// Consecutive PE vectors, one per cycle
	task automatic send_pe(input int first, input int n);
		for (int k = first; k < first + n; k++)
		begin
			pe_out_valid = 1'b1;
			for (int c = 0; c < NUM_COL; c++)
				pe_out_block[c] = pat[HDR + k * NUM_COL + c];
			@(negedge Clk_16UI);
		end
		pe_out_valid = 1'b0;
	endtask

	// ------------------------------------------------------------
	// Monitor, outputs hold the previous edge's values here
	// ------------------------------------------------------------
	always @(posedge Clk_16UI)
	begin
		if (!rst)
		begin
			if (rd_en && rd_sent)
			begin
				assert (exp_rd.size() != 0) else problem(T_RD, "read beyond the expected total");
				if (exp_rd.size() != 0)
				begin
					exp_addr = exp_rd.pop_front();
					assert (rd_addr == exp_addr) else mismatch(T_RD, exp_addr, rd_addr);
				end
				assert (rd_tid == TID_W'(rd_acc % A_BLOCK_LINES))
				else
					mismatch(T_RD, rd_acc % A_BLOCK_LINES, rd_tid);
				// B phase after the A lines of each group
				assert (a_b_workspace_sel == ((rd_acc % GROUP) >= A_BLOCK_LINES))
				else
					mismatch(T_RD, (rd_acc % GROUP) >= A_BLOCK_LINES, a_b_workspace_sel);
				rsp_q.push_back(rd_addr);
				rd_acc++;
			end
			// A channel held full in an A phase
			if (a_mem_full && (rd_acc % GROUP) < A_BLOCK_LINES)
			begin
				blocked++;
				assert (!rd_en) else problem(T_RD, "read requested while the A channel was full");
			end
			assert (!(a_mem_wr_req && b_mem_wr_req)) else problem(T_RT, "both channels written at once");
			if (a_mem_wr_req || b_mem_wr_req)
			begin
				assert (route_q.size() != 0) else problem(T_RT, "channel write with no response");
				if (route_q.size() != 0)
				begin
					exp_rt = route_q.pop_front();
					assert (b_mem_wr_req == exp_rt[ADDR_W]) else mismatch(T_RT, exp_rt[ADDR_W], b_mem_wr_req);
					assert ((b_mem_wr_req ? b_mem_addr : a_mem_addr) == exp_rt[ADDR_W-1:0])
					else
						mismatch(T_RT, exp_rt[ADDR_W-1:0], b_mem_wr_req ? b_mem_addr : a_mem_addr);
					assert ((b_mem_wr_req ? b_mem_data : a_mem_data) == rsp_line(exp_rt[ADDR_W-1:0]))
					else
						mismatch(T_RT, rsp_line(exp_rt[ADDR_W-1:0]), b_mem_wr_req ? b_mem_data : a_mem_data);
				end
				routed++;
			end
			if (wr_en)
			begin
				assert (wr_seen < vec_cnt) else problem(T_WD, "more writes than PE vectors");
				if (wr_seen < vec_cnt)
				begin
					exp_line = pe_line(wr_seen);
					// Two bursts split at grp1
					exp_waddr = wr_seen < grp1 ? C_BASE + ADDR_W'(wr_seen) :
						C_BASE + ADDR_W'(C_BURST_STRIDE + wr_seen - grp1);
					assert (wr_din == exp_line) else mismatch(T_WD, exp_line, wr_din);
					assert (wr_addr == exp_waddr) else mismatch(T_WD, exp_waddr, wr_addr);
				end
				assert (wr_tid == TID_W'(wr_seen)) else mismatch(T_TID, wr_seen, wr_tid);
				wr_seen++;
				wr_pending++;
			end
			// Completion one edge after the response count reaches the target
			assert (test_cmp == cmp_exp) else mismatch(T_CMP, cmp_exp, test_cmp);
			if (exp_rsp != 0 && rsp_dut == exp_rsp)
				cmp_exp = 1'b1;
			if (wr_rsp_valid)
				rsp_dut++;
			if (test_cmp)
				cmp_seen = 1'b1;
		end
	end

	// ------------------------------------------------------------
	// Arbiter and array side stimulus
	// ------------------------------------------------------------
	always @(negedge Clk_16UI)
	begin
		if (!rst)
		begin
			rd_sent     = ($random(seed) & 3) != 0;
			stall_rd    = ($random(seed) & 7) == 0;
			wr_alm_full = ($random(seed) & 3) == 0;
			// One stretch of A channel full inside the first A block
			if (rd_acc == 3 && !full_done)
			begin
				full_hold = 6;
				full_done = 1'b1;
			end
			a_mem_full = full_hold > 0;
			if (full_hold > 0)
				full_hold--;
			rd_rsp_valid = 1'b0;
			if (rsp_q.size() != 0 && ($random(seed) & 1))
			begin
				rsp_addr     = rsp_q.pop_front();
				rd_rsp_valid = 1'b1;
				rd_rsp_addr  = rsp_addr;
				rd_data      = rsp_line(rsp_addr);
				route_q.push_back({(rsp_idx % GROUP) >= A_BLOCK_LINES, rsp_addr});
				rsp_idx++;
			end
			wr_rsp_valid = wr_pending > 0;
			if (wr_pending > 0)
			begin
				wr_pending--;
				wr_rsp_sent++;
			end
		end
	end

	initial
	begin
		$readmemh("bench/sgemm_patterns.hex", pat);
		seed            = 86;
		nblk            = pat[0];
		npa             = pat[1];
		npb             = pat[2];
		exp_rsp         = pat[3];
		vec_cnt         = pat[4];
		grp1            = vec_cnt / 2;
		total_rd        = npa * npb * nblk * GROUP;
		Clk_16UI        = 1'b0;
		rst             = 1'b1;
		go              = 1'b0;
		num_blocks      = CNT_W'(nblk);
		num_parts_a     = CNT_W'(npa);
		num_parts_b     = CNT_W'(npb);
		expected_wr_rsp = CNT_W'(exp_rsp);
		rd_sent         = 1'b0;
		stall_rd        = 1'b0;
		rd_rsp_valid    = 1'b0;
		rd_rsp_addr     = '0;
		rd_data         = '0;
		wr_sent         = 1'b1;
		wr_rsp_valid    = 1'b0;
		wr_alm_full     = 1'b0;
		a_mem_full      = 1'b0;
		b_mem_full      = 1'b0;
		pe_out_valid    = 1'b0;
		pe_out_block    = '0;

		// Three reset edges, then one idle edge
		for (int i = 0; i < 4; i++)
		begin
			@(negedge Clk_16UI);
			check_reset_outputs();
			if (i == 2)
				rst <= 1'b0;
		end
		finish_test(T_RST);

		// B part outermost, A part next, block innermost
		for (int pb = 0; pb < npb; pb++)
			for (int pa = 0; pa < npa; pa++)
				for (int bk = 0; bk < nblk; bk++)
				begin
					for (int ln = 0; ln < A_BLOCK_LINES; ln++)
						exp_rd.push_back(A_BASE + ADDR_W'((pa * nblk + bk) * A_BLOCK_LINES + ln));
					for (int ln = 0; ln < B_BLOCK_LINES; ln++)
						exp_rd.push_back(B_BASE + ADDR_W'((pb * nblk + bk) * B_BLOCK_LINES + ln));
				end
		go = 1'b1;
		@(negedge Clk_16UI);
		go = 1'b0;

		// First burst drains before the second starts
		send_pe(0, grp1);
		t = 0;
		while (wr_seen < grp1 && t < TIMEOUT)
		begin
			@(negedge Clk_16UI);
			t++;
		end
		assert (wr_seen >= grp1) else problem(T_WD, "timeout waiting for the first burst");
		repeat (4) @(negedge Clk_16UI);
		send_pe(grp1, vec_cnt - grp1);
		t = 0;
		while (wr_seen < vec_cnt && t < TIMEOUT)
		begin
			@(negedge Clk_16UI);
			t++;
		end
		repeat (10) @(negedge Clk_16UI);
		assert (wr_seen == vec_cnt) else mismatch(T_WD, vec_cnt, wr_seen);
		finish_test(T_WD);
		finish_test(T_TID);

		t = 0;
		while (!cmp_seen && t < TIMEOUT)
		begin
			@(negedge Clk_16UI);
			t++;
		end
		assert (cmp_seen) else problem(T_CMP, "timeout waiting for test_cmp");
		repeat (10) @(negedge Clk_16UI);
		assert (wr_rsp_sent == exp_rsp) else mismatch(T_CMP, exp_rsp, wr_rsp_sent);
		finish_test(T_CMP);

		t = 0;
		while (rd_acc < total_rd && t < TIMEOUT)
		begin
			@(negedge Clk_16UI);
			t++;
		end
		t = 0;
		while (routed < total_rd && t < TIMEOUT)
		begin
			@(negedge Clk_16UI);
			t++;
		end
		repeat (10) @(negedge Clk_16UI);
		assert (rd_acc == total_rd) else mismatch(T_RD, total_rd, rd_acc);
		assert (blocked > 0) else problem(T_RD, "A channel full never seen in an A phase");
		finish_test(T_RD);
		assert (routed == total_rd) else mismatch(T_RT, total_rd, routed);
		assert (route_q.size() == 0 && rsp_q.size() == 0) else problem(T_RT, "responses left unrouted");
		finish_test(T_RT);

		total_err = 0;
		n_fail    = 0;
		for (int i = 0; i < N_TESTS; i++)
		begin
			total_err += errs[i];
			if (errs[i] != 0)
				n_fail++;
		end
		$display("Summary: %0d tests, %0d ok, %0d failed, %0d errors",
			N_TESTS, N_TESTS - n_fail, n_fail, total_err);
		if (total_err == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* bench/sgemm_patterns.hex */
// Header: num_blocks, num_parts_a, num_parts_b, expected write responses, vector count
// Then one PE vector per line: column 0, column 1, column 2 result words
00000002
00000002
00000001
00000006
00000006
3f800000 40000000 40400000
40800000 40a00000 40c00000
40e00000 41000000 41100000
c1200000 c1300000 c1400000
11223344 55667788 99aabbcc
deadbeef 0badf00d 12345678

/* tb.f */
verilog/sgemm_pkg.sv
verilog/pe_line_if.sv
verilog/rd_req_seq.sv
verilog/rd_rsp_router.sv
verilog/pe_out_buffer.sv
verilog/c_writeback.sv
verilog/sgemm_ctrl_top.sv
bench/tb_sgemm_ctrl.sv

/* Makefile */
SIM = obj_dir/Vtb_sgemm_ctrl

.PHONY: run clean

run: $(SIM)
	out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

$(SIM): tb.f $(wildcard verilog/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module tb_sgemm_ctrl -Mdir obj_dir

clean:
	rm -rf obj_dir
